// ==== dmem_pkg.sv ====
/*
 * Shared definitions for the strided data memory:
 *   word and address widths
 *   data_t and address_t vector types
 *   req_sel_t requester select
 *   ctrl_state_t burst sequencer states
 */

package dmem_pkg;

	localparam int DATA_WIDTH = 32;		// Memory word
	localparam int ADDR_WIDTH = 10;		// Length, stride, base and address

	typedef logic [DATA_WIDTH-1:0] data_t;
	typedef logic [ADDR_WIDTH-1:0] address_t;

	// 0 selects requester 1, 1 selects requester 2
	typedef logic [0:0] req_sel_t;

	typedef enum logic [1:0] {
		IDLE,		// Waiting for a request
		GRANT,		// Grant issued, start pulse to the AGU
		RUN			// AGU walking the burst
	} ctrl_state_t;

endpackage

// ==== access_if.sv ====
/*
 * Burst interface between the control module and one address generator:
 *   configuration, start pulse and stall from control
 *   element address, request and last flag back from the generator
 */

`timescale 1ns/1ps

interface access_if;
	import dmem_pkg::*;

	logic		set_run;	// One-cycle start
	address_t	length;		// Held during the burst
	address_t	stride;
	address_t	base;
	logic		stall;		// Freezes the walk

	address_t	address;	// Current element
	logic		req;		// Element issued this cycle
	logic		last;		// Final element, with req

	modport ctrl (
		output set_run, length, stride, base, stall,
		input address, req, last
	);

	modport agu (
		input set_run, length, stride, base, stall,
		output address, req, last
	);

endinterface

// ==== stride_agu.sv ====
/*
 * Strided address generator.
 * Walks length elements from base by stride, modulo DEPTH,
 * one element per unstalled cycle, and flags the last one.
 */

`timescale 1ns/1ps

module stride_agu #(
	parameter int DEPTH = 256
) (
	input logic		clock,
	input logic		reset,
	access_if.agu	acc
);
	import dmem_pkg::*;

	localparam address_t ADDR_MASK = address_t'(DEPTH - 1);

	logic		active;		// Burst in progress
	address_t	remain;		// Elements still to issue
	address_t	addr_q;

	assign acc.req		= active & ~acc.stall;
	assign acc.last		= acc.req & (remain == address_t'(1));
	assign acc.address	= addr_q;

	//////////////////////////////////////////////////////////////////////
	// Burst control
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			active <= 1'b0;
			remain <= '0;
		end else if (acc.set_run) begin
			active <= 1'b1;
			remain <= (acc.length == '0) ? address_t'(1) : acc.length;	// Zero means one
		end else if (acc.req) begin
			remain <= remain - address_t'(1);
			if (acc.last) begin
				active <= 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Address walk
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (acc.set_run) begin
			addr_q <= acc.base & ADDR_MASK;
		end else if (acc.req) begin
			addr_q <= (addr_q + acc.stride) & ADDR_MASK;	// Wraps at DEPTH
		end
	end

endmodule

// ==== dmem_ctrl.sv ====
/*
 * Data memory control.
 *   per-direction round-robin between two requesters
 *   burst sequencer (IDLE, GRANT, RUN) and configuration capture
 *   stall gating from the global stall and the granted valid
 *   store data steering and load data / strobe return
 */

`timescale 1ns/1ps

module dmem_ctrl (
	input logic					clock,
	input logic					reset,
	input logic					stall,
	input logic					st_req1,
	input logic					st_req2,
	input logic					st_valid1,
	input logic					st_valid2,
	input dmem_pkg::address_t	st_length1,
	input dmem_pkg::address_t	st_stride1,
	input dmem_pkg::address_t	st_base1,
	input dmem_pkg::address_t	st_length2,
	input dmem_pkg::address_t	st_stride2,
	input dmem_pkg::address_t	st_base2,
	input dmem_pkg::data_t		st_data1,
	input dmem_pkg::data_t		st_data2,
	input logic					ld_req1,
	input logic					ld_req2,
	input logic					ld_valid1,
	input logic					ld_valid2,
	input dmem_pkg::address_t	ld_length1,
	input dmem_pkg::address_t	ld_stride1,
	input dmem_pkg::address_t	ld_base1,
	input dmem_pkg::address_t	ld_length2,
	input dmem_pkg::address_t	ld_stride2,
	input dmem_pkg::address_t	ld_base2,
	input dmem_pkg::data_t		rd_data,
	access_if.ctrl				st_acc,
	access_if.ctrl				ld_acc,
	output logic				wr_en,
	output dmem_pkg::address_t	wr_addr,
	output dmem_pkg::data_t		wr_data,
	output logic				rd_en,
	output dmem_pkg::address_t	rd_addr,
	output logic				st_grant1,
	output logic				st_grant2,
	output logic				ld_grant1,
	output logic				ld_grant2,
	output dmem_pkg::data_t		ld_data1,
	output dmem_pkg::data_t		ld_data2,
	output logic				ld_data_vld1,
	output logic				ld_data_vld2
);
	import dmem_pkg::*;

	// Index 0 is the store direction, index 1 the load direction
	ctrl_state_t	state [2];
	req_sel_t		sel [2];	// Current or last granted requester
	req_sel_t		win [2];	// Arbitration result
	logic [1:0]		req_1;
	logic [1:0]		req_2;
	logic [1:0]		busy;
	logic [1:0]		done;
	logic			rd_vld_q;	// Read issued last cycle
	logic			ld_last_q;	// Final read issued last cycle

	assign req_1	= {ld_req1, st_req1};
	assign req_2	= {ld_req2, st_req2};
	assign done		= {ld_last_q, st_acc.last};	// Loads end after the final strobe

	//////////////////////////////////////////////////////////////////////
	// Arbitration and sequencers
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int d = 0; d < 2; d++) begin
			win[d]	= (req_1[d] & req_2[d]) ? ~sel[d] : req_sel_t'(req_2[d]);
			busy[d]	= (state[d] != IDLE);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int d = 0; d < 2; d++) begin
				state[d]	<= IDLE;
				sel[d]		<= req_sel_t'(1);	// Requester 1 wins the first tie
			end
		end else begin
			for (int d = 0; d < 2; d++) begin
				case (state[d])
					IDLE: begin
						if (req_1[d] | req_2[d]) begin
							sel[d]		<= win[d];
							state[d]	<= GRANT;
						end
					end
					GRANT:		state[d] <= RUN;
					RUN: begin
						if (done[d]) begin
							state[d] <= IDLE;
						end
					end
					default:	state[d] <= IDLE;
				endcase
			end
		end
	end

	// Configuration of the winner, captured at the grant edge
	always_ff @(posedge clock) begin
		if (!busy[0]) begin
			st_acc.length	<= win[0] ? st_length2 : st_length1;
			st_acc.stride	<= win[0] ? st_stride2 : st_stride1;
			st_acc.base		<= win[0] ? st_base2 : st_base1;
		end
		if (!busy[1]) begin
			ld_acc.length	<= win[1] ? ld_length2 : ld_length1;
			ld_acc.stride	<= win[1] ? ld_stride2 : ld_stride1;
			ld_acc.base		<= win[1] ? ld_base2 : ld_base1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			rd_vld_q	<= 1'b0;
			ld_last_q	<= 1'b0;
		end else begin
			rd_vld_q	<= ld_acc.req;
			ld_last_q	<= ld_acc.last;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Grants, stall gating and data steering
	//////////////////////////////////////////////////////////////////////

	assign st_grant1	= busy[0] & (sel[0] == 1'b0);
	assign st_grant2	= busy[0] & (sel[0] == 1'b1);
	assign ld_grant1	= busy[1] & (sel[1] == 1'b0);
	assign ld_grant2	= busy[1] & (sel[1] == 1'b1);

	assign st_acc.set_run	= (state[0] == GRANT);
	assign ld_acc.set_run	= (state[1] == GRANT);
	assign st_acc.stall		= stall | ~(sel[0] ? st_valid2 : st_valid1);
	assign ld_acc.stall		= stall | ~(sel[1] ? ld_valid2 : ld_valid1);

	assign wr_en	= st_acc.req;
	assign wr_addr	= st_acc.address;
	assign wr_data	= sel[0] ? st_data2 : st_data1;
	assign rd_en	= ld_acc.req;
	assign rd_addr	= ld_acc.address;

	assign ld_data_vld1	= rd_vld_q & ld_grant1;
	assign ld_data_vld2	= rd_vld_q & ld_grant2;
	assign ld_data1		= ld_grant1 ? rd_data : '0;	// Idle port reads zero
	assign ld_data2		= ld_grant2 ? rd_data : '0;

endmodule

// ==== dmem_array.sv ====
/*
 * Data memory array of DEPTH words.
 * One synchronous write port, one registered read port,
 * read-before-write on a same-address collision.
 */

`timescale 1ns/1ps

module dmem_array #(
	parameter int DEPTH = 256
) (
	input logic					clock,
	input logic					wr_en,
	input dmem_pkg::address_t	wr_addr,
	input dmem_pkg::data_t		wr_data,
	input logic					rd_en,
	input dmem_pkg::address_t	rd_addr,
	output dmem_pkg::data_t		rd_data
);
	import dmem_pkg::*;

	localparam int AW = $clog2(DEPTH);

	data_t mem [DEPTH];

	always_ff @(posedge clock) begin
		if (wr_en) begin
			mem[wr_addr[AW-1:0]] <= wr_data;
		end
	end

	// Old word returned on a collision
	always_ff @(posedge clock) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr[AW-1:0]];
		end
	end

endmodule

// ==== dmem_top.sv ====
/*
 * Strided data memory top level.
 * Control, store and load address generators, and the memory array,
 * joined by two burst interfaces.
 */

`timescale 1ns/1ps

module dmem_top #(
	parameter int DEPTH = 256
) (
	input logic					clock,
	input logic					reset,
	input logic					stall,
	input logic					st_req1,
	input logic					st_req2,
	input logic					st_valid1,
	input logic					st_valid2,
	input dmem_pkg::address_t	st_length1,
	input dmem_pkg::address_t	st_stride1,
	input dmem_pkg::address_t	st_base1,
	input dmem_pkg::address_t	st_length2,
	input dmem_pkg::address_t	st_stride2,
	input dmem_pkg::address_t	st_base2,
	input dmem_pkg::data_t		st_data1,
	input dmem_pkg::data_t		st_data2,
	input logic					ld_req1,
	input logic					ld_req2,
	input logic					ld_valid1,
	input logic					ld_valid2,
	input dmem_pkg::address_t	ld_length1,
	input dmem_pkg::address_t	ld_stride1,
	input dmem_pkg::address_t	ld_base1,
	input dmem_pkg::address_t	ld_length2,
	input dmem_pkg::address_t	ld_stride2,
	input dmem_pkg::address_t	ld_base2,
	output logic				st_grant1,
	output logic				st_grant2,
	output logic				ld_grant1,
	output logic				ld_grant2,
	output logic				ld_data_vld1,
	output logic				ld_data_vld2,
	output dmem_pkg::data_t		ld_data1,
	output dmem_pkg::data_t		ld_data2
);
	import dmem_pkg::*;

	logic		wr_en;
	address_t	wr_addr;
	data_t		wr_data;
	logic		rd_en;
	address_t	rd_addr;
	data_t		rd_data;

	access_if st_acc ();	// Store burst
	access_if ld_acc ();	// Load burst

	// Port names match the top ports, the array wires and the interfaces
	dmem_ctrl u_ctrl (.*);

	stride_agu #(
		.DEPTH	(DEPTH)
	) agu_st (
		.clock	(clock),
		.reset	(reset),
		.acc	(st_acc)
	);

	stride_agu #(
		.DEPTH	(DEPTH)
	) agu_ld (
		.clock	(clock),
		.reset	(reset),
		.acc	(ld_acc)
	);

	dmem_array #(
		.DEPTH	(DEPTH)
	) u_array (
		.clock		(clock),
		.wr_en		(wr_en),
		.wr_addr	(wr_addr),
		.wr_data	(wr_data),
		.rd_en		(rd_en),
		.rd_addr	(rd_addr),
		.rd_data	(rd_data)
	);

endmodule

// ==== dmem_props.sv ====
/*
 * Concurrent assertions on the data memory control, bound to dmem_ctrl:
 *   one grant per direction, no element while stalled,
 *   grants low after reset
 */

`timescale 1ns/1ps

module dmem_props (
	input logic	clock,
	input logic	reset,
	input logic	stall,
	input logic	st_grant1,
	input logic	st_grant2,
	input logic	ld_grant1,
	input logic	ld_grant2,
	input logic	wr_en,
	input logic	rd_en
);

	a_one_grant: assert property (@(posedge clock) disable iff (reset)
		!(st_grant1 && st_grant2) && !(ld_grant1 && ld_grant2))
		else $error("two grants high in one direction");

	a_stall: assert property (@(posedge clock) disable iff (reset)
		stall |-> !wr_en && !rd_en)
		else $error("element issued while stall is high");

	a_reset: assert property (@(posedge clock)
		reset |=> !(st_grant1 || st_grant2 || ld_grant1 || ld_grant2))
		else $error("grant high in the cycle after reset");

endmodule

bind dmem_ctrl dmem_props u_props (.*);

// ==== dmem_checker.sv ====
/*
 * Testbench checker for the strided data memory.
 * Keeps a memory model with written flags, rebuilds every element
 * address from the latched burst, checks arbitration order,
 * load port steering and the element count of each burst.
 */

`timescale 1ns/1ps

module dmem_checker #(
	parameter int DEPTH = 256
) (
	input logic					clock,
	input logic					reset,
	input logic					stall,
	input logic					req [2][2],		// [direction][requester]
	input logic					valid [2][2],
	input logic					grant [2][2],
	input dmem_pkg::address_t	len [2][2],
	input dmem_pkg::address_t	stride [2][2],
	input dmem_pkg::address_t	base [2][2],
	input dmem_pkg::data_t		st_data [2],
	input dmem_pkg::data_t		ld_data [2],
	input logic					ld_vld [2]
);
	import dmem_pkg::*;

	int			errors = 0;
	data_t		mem_model [DEPTH];
	bit			written [DEPTH];
	logic		gprev [2][2];
	logic		prev_req [2][2];
	int			last_sel [2];
	int			count [2];		// Writes or load strobes
	int			blen [2];
	address_t	bstr [2];
	address_t	bbase [2];
	int			issued;			// Load elements read so far
	bit			pend;			// Load read waiting for its strobe
	bit			pend_ok;
	int			pend_addr;
	data_t		pend_data;

	task automatic report(input string msg);
		$display("mismatch at %0t ns: %s", $time, msg);
		errors++;
	endtask

	function automatic int elem_addr(input int d, input int i);
		return (int'(bbase[d]) + i * int'(bstr[d])) % DEPTH;	// Stride rule, wraps
	endfunction

	always @(posedge clock) begin
		int a;
		if (reset) begin
			issued = 0;
			pend = 1'b0;
			for (int d = 0; d < 2; d++) begin
				last_sel[d] = 1;		// Requester 1 favored first
				count[d] = 0;
				for (int q = 0; q < 2; q++) begin
					gprev[d][q] = 1'b0;
					prev_req[d][q] = 1'b0;
				end
			end
		end else begin
			for (int d = 0; d < 2; d++) begin
				if (grant[d][0] && grant[d][1])
					report($sformatf("two grants in direction %0d", d));
				for (int q = 0; q < 2; q++) begin
					if (grant[d][q] && !gprev[d][q]) begin
						if (prev_req[d][0] && prev_req[d][1] && q == last_sel[d])
							report($sformatf("tie in direction %0d went to %0d again", d, q + 1));
						last_sel[d] = q;
						blen[d] = (len[d][q] == '0) ? 1 : int'(len[d][q]);
						bstr[d] = stride[d][q];
						bbase[d] = base[d][q];
						count[d] = 0;
						if (d == 1)
							issued = 0;
					end
				end
			end

			// Strobe carries the word read one cycle earlier
			for (int q = 0; q < 2; q++) begin
				if (ld_vld[q]) begin
					if (!grant[1][q] || ld_vld[1-q] || ld_data[1-q] !== '0)
						report($sformatf("load strobe %0d not on the granted port only", q + 1));
					if (!pend)
						report($sformatf("load strobe %0d with no element read", q + 1));
					else if (pend_ok && ld_data[q] !== pend_data)
						report($sformatf("load addr %0d got %h expected %h",
							pend_addr, ld_data[q], pend_data));
					count[1]++;
				end
			end
			pend = 1'b0;

			// Load element read by the port rule, before any store of this edge
			for (int q = 0; q < 2; q++) begin
				if (grant[1][q] && gprev[1][q] && valid[1][q] && !stall && issued < blen[1]) begin
					a = elem_addr(1, issued);
					pend = 1'b1;
					pend_ok = written[a];
					pend_addr = a;
					pend_data = mem_model[a];
					issued++;
				end
			end

			// Store element moves by the port rule
			for (int q = 0; q < 2; q++) begin
				if (grant[0][q] && gprev[0][q] && valid[0][q] && !stall) begin
					a = elem_addr(0, count[0]);
					mem_model[a] = st_data[q];
					written[a] = 1'b1;
					count[0]++;
				end
			end

			for (int d = 0; d < 2; d++) begin
				for (int q = 0; q < 2; q++) begin
					if (!grant[d][q] && gprev[d][q] && count[d] != blen[d])
						report($sformatf("direction %0d burst moved %0d of %0d elements",
							d, count[d], blen[d]));
					gprev[d][q] = grant[d][q];
					prev_req[d][q] = req[d][q];
				end
			end
		end
	end

endmodule

// ==== tb_dmem.sv ====
/*
 * Testbench for the strided data memory.
 *   clock, reset and random requesters (seed 70)
 *   fill, strided load, arbitration, back-pressure and concurrency tests
 *   checker instance and final report
 */

`timescale 1ns/1ps

module tb_dmem;
	import dmem_pkg::*;

	localparam int DEPTH = 256;
	localparam int TIMEOUT = 400;	// Cycles per burst

	logic		clock;
	logic		reset;
	logic		stall = 1'b0;
	logic		stall_rand;
	logic		req [2][2];			// [0] store, [1] load
	logic		valid [2][2];
	address_t	len [2][2];
	address_t	stride [2][2];
	address_t	base [2][2];
	data_t		st_data [2];
	logic		grant [2][2];
	data_t		ld_data [2];
	logic		ld_vld [2];
	bit			timed_out;
	int			tests;

	dmem_top #(.DEPTH(DEPTH)) DUT (
		.clock(clock), .reset(reset), .stall(stall),
		.st_req1(req[0][0]), .st_req2(req[0][1]),
		.st_valid1(valid[0][0]), .st_valid2(valid[0][1]),
		.st_length1(len[0][0]), .st_stride1(stride[0][0]), .st_base1(base[0][0]),
		.st_length2(len[0][1]), .st_stride2(stride[0][1]), .st_base2(base[0][1]),
		.st_data1(st_data[0]), .st_data2(st_data[1]),
		.ld_req1(req[1][0]), .ld_req2(req[1][1]),
		.ld_valid1(valid[1][0]), .ld_valid2(valid[1][1]),
		.ld_length1(len[1][0]), .ld_stride1(stride[1][0]), .ld_base1(base[1][0]),
		.ld_length2(len[1][1]), .ld_stride2(stride[1][1]), .ld_base2(base[1][1]),
		.st_grant1(grant[0][0]), .st_grant2(grant[0][1]),
		.ld_grant1(grant[1][0]), .ld_grant2(grant[1][1]),
		.ld_data_vld1(ld_vld[0]), .ld_data_vld2(ld_vld[1]),
		.ld_data1(ld_data[0]), .ld_data2(ld_data[1])
	);

	dmem_checker #(.DEPTH(DEPTH)) u_checker (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	always @(posedge clock) begin
		stall <= stall_rand ? ($urandom % 4 == 0) : 1'b0;
	end

	// One requester: raise req, randomize valid, wait for the grant to end
	task automatic run_burst(input int d, input int p, input int l, input int s, input int b);
		int cycles;
		bit seen;
		cycles = 0;
		seen = 1'b0;
		@(posedge clock);
		req[d][p] <= 1'b1;
		len[d][p] <= address_t'(l);
		stride[d][p] <= address_t'(s);
		base[d][p] <= address_t'(b);
		while (!timed_out) begin
			@(posedge clock);
			valid[d][p] <= ($urandom % 4 != 0);		// About 75 percent
			if (d == 0)
				st_data[p] <= $urandom;
			if (grant[d][p]) begin
				seen = 1'b1;
				req[d][p] <= 1'b0;			// Arbitration is done
			end else if (seen) begin
				break;
			end
			cycles++;
			if (cycles > TIMEOUT) begin
				$display("timeout: requester %0d of direction %0d saw no grant end", p + 1, d);
				timed_out = 1'b1;
			end
		end
		valid[d][p] <= 1'b0;
	endtask

	task automatic random_burst(input int d, input int p, input int lo, input int span);
		run_burst(d, p, $urandom % 8 + 1, $urandom % 16, lo + $urandom % span);
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %0d %s finished, errors so far %0d", tests, name, u_checker.errors);
	endtask

	initial begin
		void'($urandom(70));
		reset = 1'b1;
		stall_rand = 1'b0;
		timed_out = 1'b0;
		tests = 0;
		for (int d = 0; d < 2; d++) begin
			st_data[d] = '0;
			for (int p = 0; p < 2; p++) begin
				req[d][p] = 1'b0;
				valid[d][p] = 1'b0;
				len[d][p] = '0;
				stride[d][p] = '0;
				base[d][p] = '0;
			end
		end
		repeat (3) @(posedge clock);
		reset <= 1'b0;

		for (int k = 0; k < 16 && !timed_out; k++)
			run_burst(0, 0, 8, 1, k * 8);
		for (int k = 0; k < 16 && !timed_out; k++)
			run_burst(0, 1, 8, 1, 128 + k * 8);
		end_test("fill");

		for (int k = 0; k < 8 && !timed_out; k++)
			random_burst(1, k % 2, 0, 1024);
		end_test("strided load");

		for (int k = 0; k < 4 && !timed_out; k++) begin
			// Requester 1 last granted from here on so ties favor requester 2
			if (k == 1) begin
				random_burst(0, 0, 0, 1024);
				random_burst(1, 0, 0, 1024);
			end
			fork
				random_burst(0, 0, 0, 1024);
				random_burst(0, 1, 0, 1024);
				random_burst(1, 0, 0, 1024);
				random_burst(1, 1, 0, 1024);
			join
		end
		end_test("arbitration");

		stall_rand <= 1'b1;
		for (int k = 0; k < 10 && !timed_out; k++) begin
			random_burst(0, k % 2, 0, 1024);
			random_burst(1, (k + 1) % 2, 0, 1024);
		end
		end_test("back-pressure");

		// Stores stay below 128, loads above
		for (int k = 0; k < 6 && !timed_out; k++) begin
			fork
				random_burst(0, k % 2, 0, 21);
				random_burst(1, k % 2, 128, 21);
			join
		end
		for (int k = 0; k < 3 && !timed_out; k++)
			run_burst(1, k % 2, 8, 200 + k * 37, 200 + k);
		end_test("concurrency and wrap");

		repeat (4) @(posedge clock);
		$display("tests run %0d, errors %0d, timeout %0d", tests, u_checker.errors, timed_out);
		if (timed_out || u_checker.errors != 0) begin
			$display("*** TEST FAILED ***");
		end else begin
			$display("*** TEST PASSED ***");
		end
		$finish;
	end

endmodule

// ==== dmem.f ====
dmem_pkg.sv
access_if.sv
stride_agu.sv
dmem_ctrl.sv
dmem_array.sv
dmem_top.sv
dmem_props.sv
dmem_checker.sv
tb_dmem.sv

// ==== Makefile ====
# Verilator build for the strided data memory testbench

VERILATOR ?= verilator
TOP       ?= tb_dmem
FLIST     ?= dmem.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(OBJ_DIR)
